// File: hw/periph_consts.svh
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Slave base addresses. Each slave owns addr[11:8].
`define PERIPH_TIMER0_BASE	12'h000
`define PERIPH_TIMER1_BASE	12'h100
`define PERIPH_IRQC_BASE	12'h200

`define PERIPH_NUM_SLAVES	3

// Timer register selects, taken from addr[3:2].
`define TIMER_REG_COUNT		2'd0
`define TIMER_REG_RELOAD	2'd1
`define TIMER_REG_CONTROL	2'd2
`define TIMER_REG_EOI		2'd3

// Interrupt controller register selects.
`define IRQC_REG_RAW		2'd0
`define IRQC_REG_MASK		2'd1
`define IRQC_REG_MASKED		2'd2

// Number of interrupt sources.
`define PERIPH_NUM_IRQ		2

// Count and reload value out of reset.
`define TIMER_RESET_VAL		32'hffff_ffff

`endif

// File: hw/periph_pkg.sv
`default_nettype none

package periph_pkg;

	// Request driven by a master, held until its ack.
	typedef struct packed {
		logic		access;
		logic [11:0]	addr;
		logic		wr_en;
		logic [31:0]	wr_val;
	} bus_req_t;

	// Response returned to a master.
	typedef struct packed {
		logic		ack;
		logic		error;
		logic [31:0]	data;
	} bus_rsp_t;

	// Response from one slave to the decoder.
	typedef struct packed {
		logic		ack;
		logic [31:0]	data;
	} slave_rsp_t;

endpackage

`default_nettype wire

// File: hw/bus_arbiter.sv
`default_nettype none
`timescale 1ns/10ps

module bus_arbiter import periph_pkg::*; (
	input wire		clk,
	input wire		rst,
	input wire bus_req_t	host_req,
	input wire bus_req_t	dbg_req,
	input wire bus_rsp_t	bus_rsp,
	output bus_rsp_t	host_rsp,
	output bus_rsp_t	dbg_rsp,
	output bus_req_t	bus_req
);

localparam logic MASTER_HOST = 1'b0;
localparam logic MASTER_DBG = 1'b1;

logic	busy;
logic	owner;
logic	issue;
logic	last_served;
logic	block_valid;
logic	block_id;

logic	host_ok;
logic	dbg_ok;
logic	grant_ok;
logic	grant;
logic	grant_dbg;
logic	done;

assign done = busy && bus_rsp.ack;

// A master is not eligible while it owns the bus or just after its ack.
always_comb begin
	host_ok = host_req.access && !(busy && owner == MASTER_HOST) &&
		  !(block_valid && block_id == MASTER_HOST);
	dbg_ok = dbg_req.access && !(busy && owner == MASTER_DBG) &&
		 !(block_valid && block_id == MASTER_DBG);
	grant_ok = !busy || done;
	grant = grant_ok && (host_ok || dbg_ok);
	// Debug wins a round-robin tie only if the host was served last.
	grant_dbg = dbg_ok && (!host_ok || last_served == MASTER_HOST);
end

always_ff @(posedge clk) begin
	if (rst) begin
		busy <= 1'b0;
		owner <= MASTER_HOST;
		issue <= 1'b0;
		last_served <= MASTER_DBG;
		block_valid <= 1'b0;
		block_id <= MASTER_HOST;
	end else begin
		issue <= grant;
		block_valid <= done;
		if (done)
			block_id <= owner;

		if (grant) begin
			busy <= 1'b1;
			owner <= grant_dbg;
			last_served <= grant_dbg;
		end else if (done) begin
			busy <= 1'b0;
		end
	end
end

// Address and write fields follow the owner. The strobe lasts one cycle.
always_comb begin
	bus_req = (owner == MASTER_DBG) ? dbg_req : host_req;
	bus_req.access = issue;
end

always_comb begin
	host_rsp = '0;
	dbg_rsp = '0;
	if (busy) begin
		if (owner == MASTER_DBG)
			dbg_rsp = bus_rsp;
		else
			host_rsp = bus_rsp;
	end
end

endmodule

`default_nettype wire

// File: hw/periph_decoder.sv
`default_nettype none
`timescale 1ns/10ps
`include "periph_consts.svh"

module periph_decoder import periph_pkg::*; (
	input wire		clk,
	input wire		rst,
	input wire bus_req_t	bus_req,
	input wire slave_rsp_t	timer0_rsp,
	input wire slave_rsp_t	timer1_rsp,
	input wire slave_rsp_t	irqc_rsp,
	output logic		timer0_cs,
	output logic		timer1_cs,
	output logic		irqc_cs,
	output bus_rsp_t	bus_rsp
);

localparam logic [11:0] TIMER0_BASE = `PERIPH_TIMER0_BASE;
localparam logic [11:0] TIMER1_BASE = `PERIPH_TIMER1_BASE;
localparam logic [11:0] IRQC_BASE = `PERIPH_IRQC_BASE;

logic [`PERIPH_NUM_SLAVES-1:0]	slave_cs;
logic				err_ack;

always_comb begin
	slave_cs[0] = bus_req.addr[11:8] == TIMER0_BASE[11:8];
	slave_cs[1] = bus_req.addr[11:8] == TIMER1_BASE[11:8];
	slave_cs[2] = bus_req.addr[11:8] == IRQC_BASE[11:8];
end

assign timer0_cs = slave_cs[0];
assign timer1_cs = slave_cs[1];
assign irqc_cs = slave_cs[2];

// Unmapped accesses get their ack here one cycle after the strobe.
always_ff @(posedge clk) begin
	if (rst)
		err_ack <= 1'b0;
	else
		err_ack <= bus_req.access && ~|slave_cs;
end

always_comb begin
	bus_rsp = '0;
	if (slave_cs[0]) begin
		bus_rsp.ack = timer0_rsp.ack;
		bus_rsp.data = timer0_rsp.data;
	end else if (slave_cs[1]) begin
		bus_rsp.ack = timer1_rsp.ack;
		bus_rsp.data = timer1_rsp.data;
	end else if (slave_cs[2]) begin
		bus_rsp.ack = irqc_rsp.ack;
		bus_rsp.data = irqc_rsp.data;
	end else begin
		bus_rsp.ack = err_ack;
		bus_rsp.error = err_ack;
	end
end

endmodule

`default_nettype wire

// File: hw/periph_timer.sv
`default_nettype none
`timescale 1ns/10ps
`include "periph_consts.svh"

module periph_timer import periph_pkg::*; (
	input wire		clk,
	input wire		rst,
	input wire bus_req_t	bus_req,
	input wire		cs,
	output slave_rsp_t	rsp,
	output logic		irq
);

logic [31:0]	count;
logic [31:0]	reload;

logic		periodic;
logic		enabled;
logic		irq_enable;
logic		irq_active;
logic		irq_cleared;

logic [1:0]	reg_sel;
logic		timer_access;
logic		timer_write;
logic		rsp_ack;

assign reg_sel = bus_req.addr[3:2];
assign timer_access = bus_req.access && cs;
assign timer_write = timer_access && bus_req.wr_en;

assign irq = irq_active && irq_enable;

always_comb begin
	rsp.ack = rsp_ack;
	case (reg_sel)
	`TIMER_REG_COUNT: rsp.data = count;
	`TIMER_REG_RELOAD: rsp.data = reload;
	`TIMER_REG_CONTROL: rsp.data = {29'b0, irq_enable, enabled, periodic};
	default: rsp.data = 32'b0;
	endcase
end

always_ff @(posedge clk) begin
	if (rst)
		rsp_ack <= 1'b0;
	else
		rsp_ack <= timer_access;
end

always_ff @(posedge clk) begin
	if (rst) begin
		count <= `TIMER_RESET_VAL;
		reload <= `TIMER_RESET_VAL;
		periodic <= 1'b0;
		enabled <= 1'b0;
		irq_enable <= 1'b0;
		irq_active <= 1'b0;
		irq_cleared <= 1'b0;
	end else begin
		if (enabled) begin
			if (count == 32'd0) begin
				if (periodic)
					count <= reload;
				// Periodic expiry re-arms the interrupt by itself.
				if (irq_enable && (periodic || !irq_cleared))
					irq_active <= 1'b1;
			end else begin
				count <= count - 32'd1;
			end
		end

		// Bus writes take priority over the counter.
		if (timer_write) begin
			case (reg_sel)
			`TIMER_REG_RELOAD: begin
				reload <= bus_req.wr_val;
				count <= bus_req.wr_val;
				irq_cleared <= 1'b0;
			end
			`TIMER_REG_CONTROL: begin
				{irq_enable, enabled, periodic} <= bus_req.wr_val[2:0];
			end
			`TIMER_REG_EOI: begin
				irq_active <= 1'b0;
				irq_cleared <= 1'b1;
			end
			default: begin
				// Count is read-only.
			end
			endcase
		end
	end
end

endmodule

`default_nettype wire

// File: hw/irq_controller.sv
`default_nettype none
`timescale 1ns/10ps
`include "periph_consts.svh"

module irq_controller import periph_pkg::*; #(
	parameter int num_irq = `PERIPH_NUM_IRQ
) (
	input wire			clk,
	input wire			rst,
	input wire bus_req_t		bus_req,
	input wire			cs,
	input wire [num_irq-1:0]	irq_in,
	output slave_rsp_t		rsp,
	output logic			irq
);

logic [num_irq-1:0]	mask;
logic [num_irq-1:0]	masked;
logic [1:0]		reg_sel;
logic			irqc_access;
logic			rsp_ack;

assign reg_sel = bus_req.addr[3:2];
assign irqc_access = bus_req.access && cs;

// Sources are already registered in the timers.
assign masked = irq_in & mask;
assign irq = |masked;

always_comb begin
	rsp.ack = rsp_ack;
	case (reg_sel)
	`IRQC_REG_RAW: rsp.data = {{(32 - num_irq){1'b0}}, irq_in};
	`IRQC_REG_MASK: rsp.data = {{(32 - num_irq){1'b0}}, mask};
	`IRQC_REG_MASKED: rsp.data = {{(32 - num_irq){1'b0}}, masked};
	default: rsp.data = 32'b0;
	endcase
end

always_ff @(posedge clk) begin
	if (rst)
		rsp_ack <= 1'b0;
	else
		rsp_ack <= irqc_access;
end

// Only the mask is writable.
always_ff @(posedge clk) begin
	if (rst)
		mask <= '0;
	else if (irqc_access && bus_req.wr_en && reg_sel == `IRQC_REG_MASK)
		mask <= bus_req.wr_val[num_irq-1:0];
end

endmodule

`default_nettype wire

// File: hw/periph_subsystem.sv
`default_nettype none
`timescale 1ns/10ps
`include "periph_consts.svh"

module periph_subsystem import periph_pkg::*; (
	input wire		clk,
	input wire		rst,
	input wire bus_req_t	host_req,
	input wire bus_req_t	dbg_req,
	output bus_rsp_t	host_rsp,
	output bus_rsp_t	dbg_rsp,
	output logic		irq
);

bus_req_t	bus_req;
bus_rsp_t	bus_rsp;

slave_rsp_t	timer0_rsp;
slave_rsp_t	timer1_rsp;
slave_rsp_t	irqc_rsp;

logic		timer0_cs;
logic		timer1_cs;
logic		irqc_cs;

logic [`PERIPH_NUM_IRQ-1:0]	timer_irq;

bus_arbiter arb0 (
	.clk		(clk),
	.rst		(rst),
	.host_req	(host_req),
	.dbg_req	(dbg_req),
	.bus_rsp	(bus_rsp),
	.host_rsp	(host_rsp),
	.dbg_rsp	(dbg_rsp),
	.bus_req	(bus_req)
);

periph_decoder dec0 (
	.clk		(clk),
	.rst		(rst),
	.bus_req	(bus_req),
	.timer0_rsp	(timer0_rsp),
	.timer1_rsp	(timer1_rsp),
	.irqc_rsp	(irqc_rsp),
	.timer0_cs	(timer0_cs),
	.timer1_cs	(timer1_cs),
	.irqc_cs	(irqc_cs),
	.bus_rsp	(bus_rsp)
);

periph_timer timer0 (
	.clk		(clk),
	.rst		(rst),
	.bus_req	(bus_req),
	.cs		(timer0_cs),
	.rsp		(timer0_rsp),
	.irq		(timer_irq[0])
);

periph_timer timer1 (
	.clk		(clk),
	.rst		(rst),
	.bus_req	(bus_req),
	.cs		(timer1_cs),
	.rsp		(timer1_rsp),
	.irq		(timer_irq[1])
);

irq_controller #(
	.num_irq	(`PERIPH_NUM_IRQ)
) irqc0 (
	.clk		(clk),
	.rst		(rst),
	.bus_req	(bus_req),
	.cs		(irqc_cs),
	.irq_in		(timer_irq),
	.rsp		(irqc_rsp),
	.irq		(irq)
);

endmodule

`default_nettype wire

// File: tb/tb_periph_subsystem.sv
`default_nettype none
`timescale 1ns/10ps
`include "periph_consts.svh"

module tb_periph_subsystem import periph_pkg::*; ();

localparam int CLK_PERIOD = 10;
localparam int RESET_CYCLES = 16;
localparam int ACK_LIMIT = 16;
localparam int MAX_N = 47;
localparam int MAX_ACCESSES = 100;
localparam int WATCHDOG_CYCLES = RESET_CYCLES + MAX_ACCESSES * (ACK_LIMIT + 3) + 8 * MAX_N + 200;
localparam logic [31:0] RAND_SEED = 32'h1a70_c9f3;
localparam bit HOST = 1'b0;
localparam bit DBG = 1'b1;
localparam logic [11:0] T0 = `PERIPH_TIMER0_BASE;
localparam logic [11:0] T1 = `PERIPH_TIMER1_BASE;
localparam logic [11:0] IRQC = `PERIPH_IRQC_BASE;
// Control word is {irq_enable, enabled, periodic}.
localparam logic [31:0] CTRL_ONE_SHOT = 32'h6;
localparam logic [31:0] CTRL_PERIODIC = 32'h7;

logic		clk;
logic		rst;
bus_req_t	host_req;
bus_req_t	dbg_req;
bus_rsp_t	host_rsp;
bus_rsp_t	dbg_rsp;
logic		irq;

int	check_errors = 0;
int	missing_acks = 0;
int	cycle_count = 0;
// The master served last loses a tie. Out of reset the host has priority.
bit	last_dbg = 1'b1;

periph_subsystem dut0 (
	.clk		(clk),
	.rst		(rst),
	.host_req	(host_req),
	.dbg_req	(dbg_req),
	.host_rsp	(host_rsp),
	.dbg_rsp	(dbg_rsp),
	.irq		(irq)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

always @(posedge clk)
	cycle_count <= cycle_count + 1;

initial begin
	#(WATCHDOG_CYCLES * CLK_PERIOD);
	$display("Watchdog expired after %0d cycles, the tests did not finish.", WATCHDOG_CYCLES);
	$display("TEST RESULT: FAIL");
	$finish;
end

function automatic logic [11:0] reg_addr(input logic [11:0] base, input logic [1:0] sel);
	return base | {8'b0, sel, 2'b00};
endfunction

task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
	assert (got === exp) else begin
		check_errors++;
		$display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_true(input bit cond, input string what);
	assert (cond) else begin
		check_errors++;
		$display("ERROR %0t: %s", $time, what);
	end
endtask

task automatic drive_req(input bit use_dbg, input bus_req_t req);
	if (use_dbg)
		dbg_req <= req;
	else
		host_req <= req;
endtask

// One transaction on one master port with its ack latency checked.
task automatic bus_access(input bit use_dbg, input logic [11:0] addr, input bit wr,
	input logic [31:0] wval, output logic [31:0] rdata, output bit err);
	bus_req_t req;
	bus_rsp_t rsp;
	int lat;
	bit acked;
	req.access = 1'b1;
	req.addr = addr;
	req.wr_en = wr;
	req.wr_val = wval;
	lat = 0;
	acked = 1'b0;
	rdata = '0;
	err = 1'b0;
	@(posedge clk);
	drive_req(use_dbg, req);
	while (!acked && lat <= ACK_LIMIT) begin
		@(posedge clk);
		rsp = use_dbg ? dbg_rsp : host_rsp;
		if (rsp.ack)
			acked = 1'b1;
		else
			lat++;
	end
	req.access = 1'b0;
	drive_req(use_dbg, req);
	if (acked) begin
		last_dbg = use_dbg;
		rdata = rsp.data;
		err = rsp.error;
		check_equal("ack latency", lat, 32'd2);
	end else begin
		missing_acks++;
		$display("No acknowledge for the access to address %h at %0t.", addr, $time);
	end
endtask

task automatic bus_write(input bit use_dbg, input logic [11:0] addr, input logic [31:0] val);
	logic [31:0] unused;
	bit err;
	bus_access(use_dbg, addr, 1'b1, val, unused, err);
	check_true(!err, "unexpected bus error on a write");
endtask

task automatic bus_read(input bit use_dbg, input logic [11:0] addr, output logic [31:0] val);
	bit err;
	bus_access(use_dbg, addr, 1'b0, 32'h0, val, err);
	check_true(!err, "unexpected bus error on a read");
endtask

task automatic expect_read(input bit use_dbg, input logic [11:0] addr,
	input logic [31:0] exp, input string what);
	logic [31:0] val;
	bus_read(use_dbg, addr, val);
	check_equal(what, val, exp);
endtask

task automatic wait_irq(input int limit, input string what);
	int i;
	bit seen;
	seen = 1'b0;
	for (i = 0; i < limit && !seen; i++) begin
		@(posedge clk);
		seen = irq;
	end
	check_true(seen, what);
endtask

task automatic disarm_timer(input logic [11:0] base);
	bus_write(HOST, reg_addr(base, `TIMER_REG_CONTROL), 32'h0);
	bus_write(HOST, reg_addr(base, `TIMER_REG_EOI), 32'h0);
	bus_write(HOST, reg_addr(IRQC, `IRQC_REG_MASK), 32'h0);
endtask

// Both masters read in the same cycle. The loser is served two cycles later.
task automatic contend_read(input logic [11:0] host_addr, input logic [11:0] dbg_addr,
	input logic [31:0] host_exp, input logic [31:0] dbg_exp);
	bus_req_t req;
	int cyc;
	int host_at;
	int dbg_at;
	bit first_dbg;
	first_dbg = !last_dbg;
	host_at = -1;
	dbg_at = -1;
	req.access = 1'b1;
	req.wr_en = 1'b0;
	req.wr_val = 32'h0;
	@(posedge clk);
	req.addr = host_addr;
	host_req <= req;
	req.addr = dbg_addr;
	dbg_req <= req;
	for (cyc = 0; (host_at < 0 || dbg_at < 0) && cyc <= 2 * ACK_LIMIT; cyc++) begin
		@(posedge clk);
		if (host_at < 0 && host_rsp.ack) begin
			host_at = cyc;
			check_equal("host data under contention", host_rsp.data, host_exp);
			host_req.access <= 1'b0;
		end
		if (dbg_at < 0 && dbg_rsp.ack) begin
			dbg_at = cyc;
			check_equal("debug data under contention", dbg_rsp.data, dbg_exp);
			dbg_req.access <= 1'b0;
		end
	end
	host_req.access <= 1'b0;
	dbg_req.access <= 1'b0;
	if (host_at < 0 || dbg_at < 0) begin
		missing_acks++;
		$display("A master got no acknowledge under contention at %0t.", $time);
	end else begin
		check_equal("first ack cycle", first_dbg ? dbg_at : host_at, 32'd2);
		check_equal("second ack cycle", first_dbg ? host_at : dbg_at, 32'd4);
	end
	last_dbg = !first_dbg;
endtask

task automatic test_arbitration();
	logic [31:0] v;
	contend_read(reg_addr(T0, `TIMER_REG_RELOAD), reg_addr(T1, `TIMER_REG_CONTROL),
		`TIMER_RESET_VAL, 32'h0);
	v = $urandom;
	bus_write(HOST, reg_addr(T1, `TIMER_REG_RELOAD), v);
	contend_read(reg_addr(T0, `TIMER_REG_RELOAD), reg_addr(T1, `TIMER_REG_RELOAD),
		`TIMER_RESET_VAL, v);
endtask

task automatic test_registers();
	logic [31:0] val;
	logic [11:0] base;
	bit port;
	int t;
	for (t = 0; t < 2; t++) begin
		base = (t == 0) ? T0 : T1;
		port = (t == 0) ? HOST : DBG;
		val = $urandom;
		bus_write(port, reg_addr(base, `TIMER_REG_RELOAD), val);
		expect_read(port, reg_addr(base, `TIMER_REG_COUNT), val, "count after reload write");
		expect_read(port, reg_addr(base, `TIMER_REG_RELOAD), val, "reload readback");
		val = $urandom;
		bus_write(port, reg_addr(base, `TIMER_REG_CONTROL), val);
		expect_read(port, reg_addr(base, `TIMER_REG_CONTROL), val & 32'h7, "control readback");
		disarm_timer(base);
	end
	val = $urandom;
	bus_write(DBG, reg_addr(IRQC, `IRQC_REG_MASK), val);
	expect_read(DBG, reg_addr(IRQC, `IRQC_REG_MASK), val & 32'h3, "mask readback");
	bus_write(DBG, reg_addr(IRQC, `IRQC_REG_MASK), 32'h0);
endtask

task automatic test_one_shot();
	logic [31:0] n;
	int i;
	bit quiet;
	n = 32'd16 + ($urandom % 32);
	bus_write(HOST, reg_addr(T0, `TIMER_REG_RELOAD), n);
	bus_write(HOST, reg_addr(T0, `TIMER_REG_CONTROL), CTRL_ONE_SHOT);
	bus_write(HOST, reg_addr(IRQC, `IRQC_REG_MASK), 32'h1);
	wait_irq(n + 16, "one-shot irq did not rise");
	expect_read(HOST, reg_addr(T0, `TIMER_REG_COUNT), 32'h0, "count after one-shot expiry");
	bus_write(HOST, reg_addr(T0, `TIMER_REG_EOI), 32'h0);
	quiet = 1'b1;
	for (i = 0; i < 2 * n; i++) begin
		@(posedge clk);
		if (irq)
			quiet = 1'b0;
	end
	check_true(quiet, "irq returned after end-of-interrupt in one-shot mode");
	bus_write(HOST, reg_addr(T0, `TIMER_REG_RELOAD), n);
	wait_irq(n + 16, "one-shot irq did not rise after a new reload");
	disarm_timer(T0);
endtask

task automatic test_periodic();
	logic [31:0] n;
	logic [31:0] val;
	int start;
	bit seen;
	n = 32'd16 + ($urandom % 32);
	bus_write(DBG, reg_addr(T1, `TIMER_REG_RELOAD), n);
	bus_write(DBG, reg_addr(T1, `TIMER_REG_CONTROL), CTRL_PERIODIC);
	bus_write(DBG, reg_addr(IRQC, `IRQC_REG_MASK), 32'h2);
	wait_irq(n + 16, "periodic irq did not rise");
	bus_write(DBG, reg_addr(T1, `TIMER_REG_EOI), 32'h0);
	check_true(!irq, "end-of-interrupt did not clear the periodic irq");
	start = cycle_count;
	seen = 1'b0;
	while (!seen && cycle_count - start < n + 12) begin
		bus_read(DBG, reg_addr(T1, `TIMER_REG_COUNT), val);
		check_true(val <= n, "periodic count read above the reload value");
		seen = irq;
	end
	check_true(seen, "periodic irq did not return after end-of-interrupt");
	disarm_timer(T1);
endtask

task automatic test_masking();
	logic [31:0] val;
	int i;
	bit quiet;
	bus_write(HOST, reg_addr(T0, `TIMER_REG_RELOAD), 32'd4 + ($urandom % 8));
	bus_write(HOST, reg_addr(T0, `TIMER_REG_CONTROL), CTRL_ONE_SHOT);
	val = '0;
	quiet = 1'b1;
	for (i = 0; i < 12 && val[0] == 1'b0; i++) begin
		bus_read(HOST, reg_addr(IRQC, `IRQC_REG_RAW), val);
		if (irq)
			quiet = 1'b0;
	end
	check_true(quiet, "masked timer interrupt reached irq");
	expect_read(HOST, reg_addr(IRQC, `IRQC_REG_RAW), 32'h1, "raw status");
	expect_read(HOST, reg_addr(IRQC, `IRQC_REG_MASKED), 32'h0, "masked status");
	bus_write(HOST, reg_addr(IRQC, `IRQC_REG_MASK), 32'h1);
	check_true(irq, "irq did not rise after unmasking");
	disarm_timer(T0);
endtask

task automatic test_unmapped();
	logic [31:0] r;
	logic [31:0] val;
	bit err;
	r = $urandom;
	bus_write(HOST, reg_addr(T0, `TIMER_REG_RELOAD), r);
	bus_write(HOST, reg_addr(T1, `TIMER_REG_RELOAD), r);
	bus_write(HOST, reg_addr(IRQC, `IRQC_REG_MASK), 32'h3);
	// Select 1 of an aliased slave is a reload or the mask.
	bus_access(HOST, 12'h304, 1'b1, ~r & 32'hffff_fffc, val, err);
	check_true(err, "unmapped write was not answered with an error");
	check_equal("unmapped write data", val, 32'h0);
	bus_access(HOST, 12'h300, 1'b0, 32'h0, val, err);
	check_true(err, "unmapped read was not answered with an error");
	check_equal("unmapped read data", val, 32'h0);
	expect_read(HOST, reg_addr(T0, `TIMER_REG_RELOAD), r, "reload after unmapped access");
	expect_read(HOST, reg_addr(T0, `TIMER_REG_COUNT), r, "count after unmapped access");
	expect_read(HOST, reg_addr(T0, `TIMER_REG_CONTROL), 32'h0, "control after unmapped access");
	expect_read(HOST, reg_addr(T1, `TIMER_REG_RELOAD), r, "timer1 reload unchanged");
	expect_read(HOST, reg_addr(IRQC, `IRQC_REG_MASK), 32'h3, "mask after unmapped access");
	bus_write(HOST, reg_addr(IRQC, `IRQC_REG_MASK), 32'h0);
endtask

initial begin
	void'($urandom(RAND_SEED));
	rst = 1'b1;
	host_req = '0;
	dbg_req = '0;
	repeat (RESET_CYCLES) @(posedge clk);
	rst <= 1'b0;
	test_arbitration();
	test_registers();
	test_one_shot();
	test_periodic();
	test_masking();
	test_unmapped();
	@(posedge clk);
	$display("Failed checks: %0d, missing acknowledges: %0d", check_errors, missing_acks);
	if (check_errors == 0 && missing_acks == 0) begin
		$display("TEST RESULT: PASS");
	end else begin
		$display("TEST RESULT: FAIL");
	end
	$finish;
end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hw
hw/periph_pkg.sv
hw/bus_arbiter.sv
hw/periph_decoder.sv
hw/periph_timer.sv
hw/irq_controller.sv
hw/periph_subsystem.sv
tb/tb_periph_subsystem.sv

// File: Makefile
# Verilator build and run of the peripheral subsystem testbench.
TOP := tb_periph_subsystem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f
	@out="$$(./obj_dir/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
